// File: Bender.yml
package:
  name: wb_cache

sources:
  - logic/cache_pkg.sv
  - logic/tag_store.sv
  - logic/data_store.sv
  - logic/refill_buffer.sv
  - logic/cache_ctrl.sv
  - logic/cache_top.sv
  - target: simulation
    files:
      - verif/clock_gen.sv
      - verif/mem_model.sv
      - verif/cache_tb.sv

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
  input  wire logic    clock,
  input  wire logic    reset_n,
  input  wire addr_t   cpu_addr,
  input  wire logic    cpu_rd,
  input  wire logic    cpu_wr,
  input  wire lookup_t lookup,
  input  wire logic    fill_full,
  input  wire logic    mem_waitrequest,
  input  wire word_t   wb_data,
  output logic         cpu_waitrequest,
  output logic         tag_install,
  output logic         clean_victim,
  output logic         lfsr_step,
  output logic         fill_start,
  output logic         line_install,
  output way_t         victim_way_q,
  output tag_t         refill_tag,
  output set_t         refill_set,
  output word_idx_t    wb_word,
  output addr_t        mem_addr,
  output logic         mem_rd,
  output logic         mem_wr,
  output word_t        mem_wr_data
);

  localparam word_idx_t LAST_WORD = word_idx_t'(LINE_WORDS - 1);

  ctrl_state_t state_q;
  word_idx_t   wb_cnt_q;   // word currently on the bus
  logic        miss_start;
  logic        dirty_victim;
  logic        wb_load;
  logic        wb_accept;
  logic        wb_finish;
  logic        rd_issue;

  assign cpu_waitrequest = (cpu_rd | cpu_wr) & ~lookup.hit;

  assign miss_start   = (state_q == IDLE) && cpu_waitrequest;
  assign dirty_victim = lookup.victim_valid && lookup.victim_dirty;
  assign wb_load      = (state_q == WRITEBACK) && !mem_wr && (wb_cnt_q == '0);
  assign wb_accept    = (state_q == WRITEBACK) && mem_wr && !mem_waitrequest;
  assign wb_finish    = (state_q == WRITEBACK) && !mem_wr && (wb_cnt_q == LAST_WORD);
  assign rd_issue     = (miss_start && !dirty_victim) || wb_finish;

  assign lfsr_step    = miss_start;
  assign clean_victim = wb_finish;
  assign fill_start   = rd_issue;
  assign line_install = (state_q == REFILL) && fill_full;
  assign tag_install  = line_install;

  // first load fetches word 0, each accept fetches the one after
  assign wb_word = wb_cnt_q + word_idx_t'(mem_wr);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= IDLE;
      wb_cnt_q <= '0;
      mem_rd   <= 1'b0;
      mem_wr   <= 1'b0;
      mem_addr <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_start) begin
            wb_cnt_q <= '0;
            if (dirty_victim) begin
              state_q  <= WRITEBACK;
              mem_addr <= {lookup.victim_tag, addr_set(cpu_addr), 4'b0000};
            end else begin
              state_q <= REFILL;
            end
          end
        end
        WRITEBACK: begin
          if (wb_load) begin
            mem_wr <= 1'b1;
          end else if (wb_accept) begin
            if (wb_cnt_q == LAST_WORD) begin
              mem_wr <= 1'b0;
            end else begin
              wb_cnt_q <= wb_cnt_q + 2'd1;
              mem_addr <= mem_addr + 32'd4;
            end
          end else if (wb_finish) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (mem_rd && !mem_waitrequest)
            mem_rd <= 1'b0;  // held until memory takes it
          if (fill_full)
            state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
      if (rd_issue) begin
        mem_rd   <= 1'b1;
        mem_addr <= {cpu_addr[31:2], 2'b00};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wb_load || (wb_accept && wb_cnt_q != LAST_WORD))
      mem_wr_data <= wb_data;
    if (miss_start) begin
      victim_way_q <= lookup.victim_way;
      refill_tag   <= addr_tag(cpu_addr);
      refill_set   <= addr_set(cpu_addr);
    end
  end

  a_rd_wr_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
    !(mem_rd && mem_wr));

endmodule

`default_nettype wire

// File: logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

  localparam int WAYS       = 4;
  localparam int LINE_WORDS = 4;
  localparam int SETS       = 16;

  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;
  typedef logic [3:0]   be_t;      // bit 3 is the top byte
  typedef logic [127:0] line_t;    // word 0 sits in the top 32 bits
  typedef logic [23:0]  tag_t;
  typedef logic [3:0]   set_t;
  typedef logic [1:0]   word_idx_t;
  typedef logic [1:0]   way_t;

  typedef struct packed {
    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_valid;
    logic victim_dirty;
    tag_t victim_tag;
  } lookup_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITEBACK,
    REFILL
  } ctrl_state_t;

  function automatic tag_t addr_tag(addr_t addr);
    return addr[31:8];
  endfunction

  function automatic set_t addr_set(addr_t addr);
    return addr[7:4];
  endfunction

  function automatic word_idx_t addr_word(addr_t addr);
    return addr[3:2];
  endfunction

endpackage

`default_nettype wire

// File: logic/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
  parameter logic [10:0] lfsr_seed = 11'd101
) (
  input  wire logic  clock,
  input  wire logic  reset_n,
  input  wire addr_t cpu_addr,
  input  wire logic  cpu_rd,
  input  wire logic  cpu_wr,
  input  wire be_t   cpu_be,
  input  wire word_t cpu_wr_data,
  output logic       cpu_rd_valid,
  output word_t      cpu_rd_data,
  output logic       cpu_waitrequest,
  output addr_t      mem_addr,
  output logic       mem_rd,
  output logic       mem_wr,
  output word_t      mem_wr_data,
  input  wire word_t mem_rd_data,
  input  wire logic  mem_rd_valid,
  input  wire logic  mem_waitrequest
);

  lookup_t   lookup;
  logic      write_hit;
  logic      tag_install;
  logic      clean_victim;
  logic      lfsr_step;
  logic      fill_start;
  logic      fill_full;
  logic      line_install;
  way_t      victim_way_q;
  tag_t      refill_tag;
  set_t      refill_set;
  word_idx_t wb_word;
  word_t     wb_data;
  line_t     fill_line;

  assign write_hit    = cpu_wr & lookup.hit;
  assign cpu_rd_valid = cpu_rd & lookup.hit;

  tag_store #(
    .lfsr_seed (lfsr_seed)
  ) tag_store_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .set          (addr_set(cpu_addr)),
    .tag          (addr_tag(cpu_addr)),
    .tag_install  (tag_install),
    .write_hit    (write_hit),
    .clean_victim (clean_victim),
    .lfsr_step    (lfsr_step),
    .victim_way_q (victim_way_q),
    .refill_tag   (refill_tag),
    .refill_set   (refill_set),
    .lookup       (lookup)
  );

  data_store data_store_i (
    .clock        (clock),
    .set          (addr_set(cpu_addr)),
    .word         (addr_word(cpu_addr)),
    .hit_way      (lookup.hit_way),
    .write_hit    (write_hit),
    .be           (cpu_be),
    .wr_data      (cpu_wr_data),
    .line_install (line_install),
    .victim_way_q (victim_way_q),
    .fill_line    (fill_line),
    .wb_word      (wb_word),
    .rd_word      (cpu_rd_data),
    .wb_data      (wb_data)
  );

  refill_buffer refill_buffer_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .fill_start   (fill_start),
    .start_word   (addr_word(cpu_addr)),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_valid (mem_rd_valid),
    .line         (fill_line),
    .full         (fill_full)
  );

  cache_ctrl cache_ctrl_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .lookup          (lookup),
    .fill_full       (fill_full),
    .mem_waitrequest (mem_waitrequest),
    .wb_data         (wb_data),
    .cpu_waitrequest (cpu_waitrequest),
    .tag_install     (tag_install),
    .clean_victim    (clean_victim),
    .lfsr_step       (lfsr_step),
    .fill_start      (fill_start),
    .line_install    (line_install),
    .victim_way_q    (victim_way_q),
    .refill_tag      (refill_tag),
    .refill_set      (refill_set),
    .wb_word         (wb_word),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data)
  );

endmodule

`default_nettype wire

// File: logic/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store import cache_pkg::*; (
  input  wire logic      clock,
  input  wire set_t      set,
  input  wire word_idx_t word,
  input  wire way_t      hit_way,
  input  wire logic      write_hit,
  input  wire be_t       be,
  input  wire word_t     wr_data,
  input  wire logic      line_install,
  input  wire way_t      victim_way_q,
  input  wire line_t     fill_line,
  input  wire word_idx_t wb_word,
  output word_t          rd_word,
  output word_t          wb_data
);

  line_t data_q [SETS][WAYS];
  line_t hit_line;
  line_t victim_line;
  word_t be_mask;

  assign hit_line    = data_q[set][hit_way];
  assign victim_line = data_q[set][victim_way_q];

  // word 0 is the top slice
  assign rd_word = hit_line[(LINE_WORDS - 1 - word) * 32 +: 32];
  assign wb_data = victim_line[(LINE_WORDS - 1 - wb_word) * 32 +: 32];

  always_comb begin
    for (int b = 0; b < 4; b++)
      be_mask[8 * b +: 8] = {8{be[b]}};
  end

  always_ff @(posedge clock) begin
    if (line_install)
      data_q[set][victim_way_q] <= fill_line;
    else if (write_hit)
      data_q[set][hit_way][(LINE_WORDS - 1 - word) * 32 +: 32] <=
        (rd_word & ~be_mask) | (wr_data & be_mask);
  end

endmodule

`default_nettype wire

// File: logic/refill_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module refill_buffer import cache_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset_n,
  input  wire logic      fill_start,
  input  wire word_idx_t start_word,
  input  wire word_t     mem_rd_data,
  input  wire logic      mem_rd_valid,
  output line_t          line,
  output logic           full
);

  word_idx_t             idx_q;
  logic [LINE_WORDS-1:0] valid_q;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      idx_q   <= '0;
      valid_q <= '0;
    end else if (fill_start) begin
      idx_q   <= start_word;  // burst wraps from the requested word
      valid_q <= '0;
    end else if (mem_rd_valid) begin
      idx_q          <= idx_q + 2'd1;
      valid_q[idx_q] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_rd_valid)
      line[(LINE_WORDS - 1 - idx_q) * 32 +: 32] <= mem_rd_data;
  end

  assign full = &valid_q;

  // memory must not send more than one burst per fill
  a_no_overrun: assert property (@(posedge clock) disable iff (!reset_n)
    full |-> !mem_rd_valid);

endmodule

`default_nettype wire

// File: logic/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store import cache_pkg::*; #(
  parameter logic [10:0] lfsr_seed = 11'd101
) (
  input  wire logic clock,
  input  wire logic reset_n,
  input  wire set_t set,
  input  wire tag_t tag,
  input  wire logic tag_install,
  input  wire logic write_hit,
  input  wire logic clean_victim,
  input  wire logic lfsr_step,
  input  wire way_t victim_way_q,
  input  wire tag_t refill_tag,
  input  wire set_t refill_set,
  output lookup_t   lookup
);

  tag_t            tags_q  [SETS][WAYS];
  logic [WAYS-1:0] valid_q [SETS];
  logic [WAYS-1:0] dirty_q [SETS];
  logic [10:0]     lfsr_q;
  logic [WAYS-1:0] way_hit;
  way_t            rand_way;
  way_t            victim;

  // x^11 + x^9 + 1, advanced two bits per step
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      lfsr_q <= lfsr_seed;
    else if (lfsr_step)
      lfsr_q <= {lfsr_q[1] ^ lfsr_q[3], lfsr_q[0] ^ lfsr_q[2], lfsr_q[10:2]};
  end

  assign rand_way = lfsr_q[1:0];

  always_comb begin
    for (int k = 0; k < WAYS; k++)
      way_hit[k] = valid_q[set][k] && (tags_q[set][k] == tag);
  end

  // invalid way first, then a clean one from the random start
  always_comb begin
    logic found;
    way_t cand;
    found  = 1'b0;
    victim = rand_way;
    cand   = rand_way;
    for (int k = 0; k < WAYS; k++) begin
      if (!found && !valid_q[set][k]) begin
        victim = way_t'(k);
        found  = 1'b1;
      end
    end
    for (int k = 0; k < WAYS; k++) begin
      cand = rand_way + way_t'(k);
      if (!found && !dirty_q[set][cand]) begin
        victim = cand;
        found  = 1'b1;
      end
    end
  end

  always_comb begin
    lookup         = '0;
    lookup.hit     = |way_hit;
    for (int k = 0; k < WAYS; k++)
      if (way_hit[k])
        lookup.hit_way = way_t'(k);
    lookup.victim_way   = victim;
    lookup.victim_valid = valid_q[set][victim];
    lookup.victim_dirty = dirty_q[set][victim];
    lookup.victim_tag   = tags_q[set][victim];
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else begin
      if (write_hit)
        dirty_q[set][lookup.hit_way] <= 1'b1;
      if (clean_victim)
        dirty_q[refill_set][victim_way_q] <= 1'b0;
      if (tag_install) begin
        valid_q[refill_set][victim_way_q] <= 1'b1;
        dirty_q[refill_set][victim_way_q] <= 1'b0; // a held write hits next cycle and dirties it
      end
    end
  end

  always_ff @(posedge clock) begin
    if (tag_install)
      tags_q[refill_set][victim_way_q] <= refill_tag;
  end

  a_single_hit: assert property (@(posedge clock) disable iff (!reset_n) $onehot0(way_hit));

endmodule

`default_nettype wire

// File: project.f
logic/cache_pkg.sv
logic/tag_store.sv
logic/data_store.sv
logic/refill_buffer.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/clock_gen.sv
verif/mem_model.sv
verif/cache_tb.sv

// File: verif/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

  localparam int mem_words      = 4096;
  localparam int accesses       = 250;
  localparam int cycles_each    = 80;  // dirty miss with stalls, plus margin
  localparam int timeout_cycles = accesses * cycles_each;

  logic  clock;
  logic  reset_n;
  addr_t cpu_addr;
  logic  cpu_rd;
  logic  cpu_wr;
  be_t   cpu_be;
  word_t cpu_wr_data;
  logic  cpu_rd_valid;
  word_t cpu_rd_data;
  logic  cpu_waitrequest;
  addr_t mem_addr;
  logic  mem_rd;
  logic  mem_wr;
  word_t mem_wr_data;
  word_t mem_rd_data;
  logic  mem_rd_valid;
  logic  mem_waitrequest;
  int    rd_count;
  int    wr_count;

  logic [7:0] ref_bytes [mem_words * 4];  // processor view, byte by byte
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;

  clock_gen clock_gen_i (
    .clock   (clock),
    .reset_n (reset_n)
  );

  mem_model #(
    .words (mem_words)
  ) mem_model_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid),
    .mem_waitrequest (mem_waitrequest),
    .rd_count        (rd_count),
    .wr_count        (wr_count)
  );

  cache_top #(
    .lfsr_seed (11'd101)
  ) cache_top_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_addr        (cpu_addr),
    .cpu_rd          (cpu_rd),
    .cpu_wr          (cpu_wr),
    .cpu_be          (cpu_be),
    .cpu_wr_data     (cpu_wr_data),
    .cpu_rd_valid    (cpu_rd_valid),
    .cpu_rd_data     (cpu_rd_data),
    .cpu_waitrequest (cpu_waitrequest),
    .mem_addr        (mem_addr),
    .mem_rd          (mem_rd),
    .mem_wr          (mem_wr),
    .mem_wr_data     (mem_wr_data),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid),
    .mem_waitrequest (mem_waitrequest)
  );

  function automatic word_t fresh_word(addr_t addr);
    return (addr * 32'h0001_0003) ^ 32'hc3a5_5a3c;
  endfunction

  function automatic addr_t line_addr(tag_t tag, set_t set, word_idx_t word);
    return {tag, set, word, 2'b00};
  endfunction

  function automatic word_t ref_read(addr_t addr);
    word_t w;
    for (int b = 0; b < 4; b++)
      w[8 * b +: 8] = ref_bytes[int'(addr[13:2]) * 4 + b];
    return w;
  endfunction

  function automatic void ref_write(addr_t addr, be_t be, word_t data);
    for (int b = 0; b < 4; b++)
      if (be[b])
        ref_bytes[int'(addr[13:2]) * 4 + b] = data[8 * b +: 8];
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic cpu_access(input addr_t addr, input logic wr, input be_t be,
                            input word_t data, output word_t rd_data, output logic rd_valid);
    @(posedge clock);
    cpu_addr    <= addr;
    cpu_rd      <= !wr;
    cpu_wr      <= wr;
    cpu_be      <= be;
    cpu_wr_data <= data;
    do
      @(negedge clock);
    while (cpu_waitrequest);
    rd_data  = cpu_rd_data;
    rd_valid = cpu_rd_valid;
    @(posedge clock);  // hit completes here
    cpu_rd <= 1'b0;
    cpu_wr <= 1'b0;
  endtask

  task automatic read_check(input string name, input addr_t addr);
    word_t data;
    logic  valid;
    cpu_access(addr, 1'b0, 4'h0, '0, data, valid);
    if (valid !== 1'b1) begin
      errors++;
      $display("%s: read of %h finished without cpu_rd_valid", name, addr);
    end
    check_word(name, ref_read(addr), data);
  endtask

  task automatic write_word(input addr_t addr, input be_t be, input word_t data);
    word_t unused_data;
    logic  unused_valid;
    cpu_access(addr, 1'b1, be, data, unused_data, unused_valid);
    ref_write(addr, be, data);
  endtask

  task automatic miss_then_hit();
    int reads_before;
    reads_before = rd_count;
    read_check("miss_then_hit", line_addr(24'd1, 4'd1, 2'd2));
    check_count("miss_then_hit refills", reads_before + 1, rd_count);
    read_check("miss_then_hit", line_addr(24'd1, 4'd1, 2'd0));
    read_check("miss_then_hit", line_addr(24'd1, 4'd1, 2'd3));
    check_count("miss_then_hit refills", reads_before + 1, rd_count);
    check_count("miss_then_hit writebacks", 0, wr_count);
  endtask

  task automatic byte_write();
    addr_t a;
    a = line_addr(24'd2, 4'd1, 2'd1);
    write_word(a, 4'b0110, 32'hdead_beef);  // write miss, then merge
    read_check("byte_write", a);
    write_word(a, 4'b1001, 32'h1234_5678);  // write hit
    read_check("byte_write", a);
  endtask

  task automatic invalid_ways_first();
    int reads_before;
    reads_before = rd_count;
    for (int k = 0; k < WAYS; k++) begin
      read_check("invalid_ways", line_addr(tag_t'(8 + k), 4'd5, word_idx_t'(k)));
      check_count("invalid_ways refills", reads_before + k + 1, rd_count);
    end
    for (int k = 0; k < WAYS; k++)
      read_check("invalid_ways", line_addr(tag_t'(8 + k), 4'd5, word_idx_t'(k)));
    check_count("invalid_ways rereads", reads_before + WAYS, rd_count);
  endtask

  task automatic dirty_eviction();
    addr_t addrs [5];
    addr_t base;
    logic  stale;
    int    held_in_cache;
    int    reads_before;
    int    writes_before;
    int    writes_after;
    held_in_cache = 0;
    writes_before = wr_count;
    for (int k = 0; k < 5; k++) begin
      addrs[k] = line_addr(tag_t'(16 + k), 4'd9, word_idx_t'(k));
      write_word(addrs[k], 4'hf, $urandom);
    end
    for (int k = 0; k < 5; k++)
      read_check("dirty_eviction", addrs[k]);
    writes_after = wr_count;
    for (int k = 0; k < 5; k++) begin
      base  = {addrs[k][31:4], 4'b0000};
      stale = 1'b0;
      for (int w = 0; w < LINE_WORDS; w++)
        if (mem_model_i.mem[int'(base[13:2]) + w] !== ref_read(base + addr_t'(4 * w)))
          stale = 1'b1;
      // memory behind the processor view, so the line has to be resident
      if (stale) begin
        held_in_cache++;
        reads_before = rd_count;
        read_check("dirty_eviction", addrs[k]);
        check_count("dirty_eviction resident line", reads_before, rd_count);
      end
    end
    // each line leaves the set dirty at most once
    check_count("dirty_eviction writeback words", LINE_WORDS * (5 - held_in_cache),
                writes_after - writes_before);
  endtask

  task automatic random_traffic();
    addr_t a;
    be_t   be;
    logic  wr;
    word_t data;
    for (int n = 0; n < 200; n++) begin
      a    = line_addr(tag_t'($urandom % 8), set_t'(2 + $urandom % 3),
                       word_idx_t'($urandom % 4));
      wr   = 1'($urandom % 2);
      be   = be_t'($urandom % 16);
      data = $urandom;
      if (wr)
        write_word(a, be, data);
      else
        read_check("random_traffic", a);
    end
  endtask

  // watchdog
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, a request never finished", cycles);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h2e0e));
    cpu_addr    = '0;
    cpu_rd      = 1'b0;
    cpu_wr      = 1'b0;
    cpu_be      = '0;
    cpu_wr_data = '0;
    for (int i = 0; i < mem_words; i++)
      ref_write(addr_t'(4 * i), 4'hf, fresh_word(addr_t'(4 * i)));
    wait (reset_n === 1'b1);
    miss_then_hit();
    byte_write();
    invalid_ways_first();
    dirty_eviction();
    random_traffic();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int half_ns      = 2,
  parameter int reset_cycles = 4
) (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #half_ns clock = ~clock;
  end

  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import cache_pkg::*; #(
  parameter int words = 4096
) (
  input  wire logic  clock,
  input  wire logic  reset_n,
  input  wire addr_t mem_addr,
  input  wire logic  mem_rd,
  input  wire logic  mem_wr,
  input  wire word_t mem_wr_data,
  output word_t      mem_rd_data,
  output logic       mem_rd_valid,
  output logic       mem_waitrequest,
  output int         rd_count,
  output int         wr_count
);

  word_t mem [words];
  addr_t burst_addr;
  int    beats_left;

  function automatic int index(addr_t addr);
    return int'(addr[31:2]) % words;
  endfunction

  // fresh contents follow the byte address
  initial begin
    for (int i = 0; i < words; i++)
      mem[i] = (addr_t'(4 * i) * 32'h0001_0003) ^ 32'hc3a5_5a3c;
  end

  always @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      mem_waitrequest <= 1'b0;
      mem_rd_valid    <= 1'b0;
      mem_rd_data     <= '0;
      burst_addr      <= '0;
      beats_left      <= 0;
      rd_count        <= 0;
      wr_count        <= 0;
    end else begin
      mem_waitrequest <= ($urandom % 4) == 0;  // stall about one cycle in four
      mem_rd_valid    <= 1'b0;
      if (mem_wr && !mem_waitrequest) begin
        mem[index(mem_addr)] <= mem_wr_data;
        wr_count             <= wr_count + 1;
      end
      if (mem_rd && !mem_waitrequest) begin
        burst_addr <= mem_addr;
        beats_left <= LINE_WORDS;
        rd_count   <= rd_count + 1;
      end else if (beats_left != 0 && ($urandom % 4) != 0) begin
        mem_rd_valid <= 1'b1;
        mem_rd_data  <= mem[index(burst_addr)];
        burst_addr   <= {burst_addr[31:4], burst_addr[3:2] + 2'd1, 2'b00}; // wraps in the line
        beats_left   <= beats_left - 1;
      end
    end
  end

endmodule

`default_nettype wire
